// ==== Bender.yml ====
package:
  name: laser310_bus

sources:
  - files:
      - source/laser_pkg.sv
      - source/cpu_clock_seq.sv
      - source/byte_ram.sv
      - source/memory_map.sv
      - source/key_matrix.sv
      - source/io_port.sv
      - source/laser310_core.sv
  - target: test
    files:
      - tb/tb_laser310_properties.sv
      - tb/tb_laser310.sv

// ==== compile.f ====
source/laser_pkg.sv
source/cpu_clock_seq.sv
source/byte_ram.sv
source/memory_map.sv
source/key_matrix.sv
source/io_port.sv
source/laser310_core.sv
tb/tb_laser310_properties.sv
tb/tb_laser310.sv

// ==== source/byte_ram.sv ====
`timescale 1ns/10ps

module byte_ram #(
	parameter int ADDR_W = 14
) (
	input  logic                 CLK50MHZ,
	input  logic                 we_i,
	input  logic [ADDR_W-1:0]    addr_i,
	input  laser_pkg::byte_t     data_i,
	output laser_pkg::byte_t     q_o
);

	laser_pkg::byte_t mem [2**ADDR_W];

	// Read returns the old byte on a write cycle
	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[addr_i] <= data_i;
		q_o <= mem[addr_i];
	end

endmodule

// ==== source/cpu_clock_seq.sv ====
`timescale 1ns/10ps

module cpu_clock_seq (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic bus_strobe_o
);

	logic [3:0] step;
	logic [3:0] step_last;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			step         <= 4'd0;
			step_last    <= laser_pkg::SEQ_NORMAL_LAST;
			cpu_clk_o    <= 1'b0;
			bus_strobe_o <= 1'b0;
		end
		else
		begin
			cpu_clk_o    <= (step == 4'd0);
			bus_strobe_o <= cpu_clk_o;	// One cycle behind the CPU clock

			// Period length is fixed at the start of each period
			if (step == 4'd0)
			begin
				step_last <= turbo_i ? laser_pkg::SEQ_TURBO_LAST
					: laser_pkg::SEQ_NORMAL_LAST;
			end

			if (step == step_last)
				step <= 4'd0;
			else
				step <= step + 4'd1;
		end
	end

endmodule

// ==== source/io_port.sv ====
`timescale 1ns/10ps

module io_port (
	input  logic                   CLK50MHZ,
	input  logic                   RESET_N,
	input  logic                   bus_strobe_i,
	input  logic                   io_sel_i,
	input  logic                   joy_sel_i,
	input  logic                   wr_i,
	input  laser_pkg::addr_t       cpu_addr_i,
	input  laser_pkg::byte_t       cpu_data_i,
	input  laser_pkg::key_matrix_t keys_i,
	input  logic                   fire_i,
	input  logic                   up_i,
	input  logic                   down_i,
	input  logic                   left_i,
	input  logic                   right_i,
	input  logic                   arm_i,
	output laser_pkg::byte_t       key_data_o,
	output laser_pkg::byte_t       joy_data_o,
	output logic [1:0]             speaker_o,
	output logic                   cass_out_o,
	output logic                   vdg_ag_o,
	output logic                   vdg_css_o
);

	logic [5:0] col_hit;	// Column has a pressed key in a selected row

	// Rows are selected by low address bits at 0
	always_comb
	begin
		col_hit = 6'd0;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 6; c++)
				if (!cpu_addr_i[r] && !keys_i[r*8+c])
					col_hit[c] = 1'b1;
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_data_o <= laser_pkg::IDLE_BYTE;
			speaker_o  <= 2'b00;
			cass_out_o <= 1'b0;
			vdg_ag_o   <= 1'b0;
			vdg_css_o  <= 1'b0;
		end
		else if (bus_strobe_i)
		begin
			key_data_o <= {2'b11, ~col_hit};	// Cassette input bit reads as 1
			if (io_sel_i && wr_i)
			begin
				speaker_o  <= {cpu_data_i[0], cpu_data_i[5]};
				cass_out_o <= cpu_data_i[2];
				vdg_ag_o   <= cpu_data_i[3];	// Graphics mode
				vdg_css_o  <= cpu_data_i[4];	// Colour set
			end
		end
	end

	// Joystick 1 switches are active low
	always_comb
	begin
		if (!joy_sel_i)
			joy_data_o = laser_pkg::IDLE_BYTE;
		else if (cpu_addr_i[7:0] == laser_pkg::JOY_DIR_PORT)
			joy_data_o = {3'b111, ~fire_i, ~right_i, ~left_i, ~down_i, ~up_i};
		else
			joy_data_o = {3'b111, ~arm_i, 4'b1111};
	end

endmodule

// ==== source/key_matrix.sv ====
`timescale 1ns/10ps

module key_matrix (
	input  logic                   CLK50MHZ,
	input  logic                   RESET_N,
	input  logic                   key_strobe_i,
	input  logic                   key_pressed_i,
	input  laser_pkg::scan_t       key_code_i,
	output laser_pkg::key_matrix_t keys_o
);

	logic [5:0] key_idx;
	logic       key_hit;

	// PS/2 set 2 code to matrix bit
	always_comb
	begin
		key_hit = 1'b1;
		case (key_code_i)
			8'h16: key_idx = 6'd28;	// 1
			8'h1E: key_idx = 6'd25;	// 2
			8'h26: key_idx = 6'd27;	// 3
			8'h25: key_idx = 6'd29;	// 4
			8'h2E: key_idx = 6'd24;	// 5
			8'h36: key_idx = 6'd40;	// 6
			8'h3D: key_idx = 6'd45;	// 7
			8'h3E: key_idx = 6'd43;	// 8
			8'h46: key_idx = 6'd41;	// 9
			8'h45: key_idx = 6'd44;	// 0
			8'h4E: key_idx = 6'd42;	// Minus
			8'h41: key_idx = 6'd35;	// Comma
			8'h49: key_idx = 6'd33;	// Period
			8'h4C: key_idx = 6'd60;	// Colon on the semicolon key
			8'h52: key_idx = 6'd58;	// Quote
			8'h5A: key_idx = 6'd50;	// Return
			8'h29: key_idx = 6'd36;	// Space
			8'h14: key_idx = 6'd10;	// Ctrl
			8'h12: key_idx = 6'd18;	// Left shift
			8'h15: key_idx = 6'd4;	// Q
			8'h1D: key_idx = 6'd1;	// W
			8'h24: key_idx = 6'd3;	// E
			8'h2D: key_idx = 6'd5;	// R
			8'h2C: key_idx = 6'd0;	// T
			8'h35: key_idx = 6'd48;	// Y
			8'h3C: key_idx = 6'd53;	// U
			8'h43: key_idx = 6'd51;	// I
			8'h44: key_idx = 6'd49;	// O
			8'h4D: key_idx = 6'd52;	// P
			8'h1C: key_idx = 6'd12;	// A
			8'h1B: key_idx = 6'd9;	// S
			8'h23: key_idx = 6'd11;	// D
			8'h2B: key_idx = 6'd13;	// F
			8'h34: key_idx = 6'd8;	// G
			8'h33: key_idx = 6'd56;	// H
			8'h3B: key_idx = 6'd61;	// J
			8'h42: key_idx = 6'd59;	// K
			8'h4B: key_idx = 6'd57;	// L
			8'h1A: key_idx = 6'd20;	// Z
			8'h22: key_idx = 6'd17;	// X
			8'h21: key_idx = 6'd19;	// C
			8'h2A: key_idx = 6'd21;	// V
			8'h32: key_idx = 6'd16;	// B
			8'h31: key_idx = 6'd32;	// N
			8'h3A: key_idx = 6'd37;	// M
			default:
			begin
				key_idx = 6'd0;
				key_hit = 1'b0;	// Not on this keyboard
			end
		endcase
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			keys_o <= '1;	// All released
		else if (key_strobe_i && key_hit)
			keys_o[key_idx] <= ~key_pressed_i;
	end

endmodule

// ==== source/laser310_core.sv ====
`timescale 1ns/10ps

module laser310_core (
	input  logic             CLK50MHZ,
	input  logic             RESET_N,
	input  logic             turbo_i,
	input  laser_pkg::addr_t cpu_addr_i,
	input  laser_pkg::byte_t cpu_data_i,
	input  logic             mreq_i,
	input  logic             iorq_i,
	input  logic             rd_i,
	input  logic             wr_i,
	input  logic             key_strobe_i,
	input  logic             key_pressed_i,
	input  laser_pkg::scan_t key_code_i,
	input  logic             fire_i,
	input  logic             up_i,
	input  logic             down_i,
	input  logic             left_i,
	input  logic             right_i,
	input  logic             arm_i,
	output logic             cpu_clk_o,
	output laser_pkg::byte_t cpu_data_o,
	output logic [1:0]       speaker_o,
	output logic             cass_out_o,
	output logic             vdg_ag_o,
	output logic             vdg_css_o
);

	logic                   bus_strobe;
	logic                   wr_cycle;
	logic                   io_sel;
	logic                   joy_sel;
	laser_pkg::byte_t       key_data;
	laser_pkg::byte_t       joy_data;
	laser_pkg::key_matrix_t keys;

	// A write counts only without a read
	assign wr_cycle = wr_i && !rd_i;

	cpu_clock_seq u_seq (
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.turbo_i      (turbo_i),
		.cpu_clk_o    (cpu_clk_o),
		.bus_strobe_o (bus_strobe)
	);

	memory_map u_map (
		.CLK50MHZ     (CLK50MHZ),
		.bus_strobe_i (bus_strobe),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_data_i   (cpu_data_i),
		.mreq_i       (mreq_i),
		.iorq_i       (iorq_i),
		.wr_i         (wr_cycle),
		.key_data_i   (key_data),
		.joy_data_i   (joy_data),
		.cpu_data_o   (cpu_data_o),
		.io_sel_o     (io_sel),
		.joy_sel_o    (joy_sel)
	);

	key_matrix u_keys (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.keys_o        (keys)
	);

	io_port u_io (
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.bus_strobe_i (bus_strobe),
		.io_sel_i     (io_sel),
		.joy_sel_i    (joy_sel),
		.wr_i         (wr_cycle),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_data_i   (cpu_data_i),
		.keys_i       (keys),
		.fire_i       (fire_i),
		.up_i         (up_i),
		.down_i       (down_i),
		.left_i       (left_i),
		.right_i      (right_i),
		.arm_i        (arm_i),
		.key_data_o   (key_data),
		.joy_data_o   (joy_data),
		.speaker_o    (speaker_o),
		.cass_out_o   (cass_out_o),
		.vdg_ag_o     (vdg_ag_o),
		.vdg_css_o    (vdg_css_o)
	);

endmodule

// ==== source/laser_pkg.sv ====
package laser_pkg;

	// Bus and keyboard types
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [63:0] key_matrix_t;	// Bit row*8+col is 0 when pressed
	typedef logic [7:0]  scan_t;

	// Memory map compared against the upper address bits
	// 6800-6FFF keyboard and output latch
	// 7000-77FF video RAM
	// 7800-B7FF base RAM
	localparam logic [4:0] IO_BASE      = 5'b01101;	// 6800 block
	localparam logic [4:0] VRAM_BASE    = 5'b01110;	// 7000 block
	localparam logic [4:0] RAM_LO_BASE  = 5'b01111;	// 7800 block
	localparam logic [3:0] RAM_HI_FIRST = 4'h8;
	localparam logic [3:0] RAM_HI_LAST  = 4'hA;
	localparam logic [4:0] RAM_HI_TAIL  = 5'b10110;	// B000-B7FF

	localparam int RAM_ADDR_W  = 14;
	localparam int VRAM_ADDR_W = 11;

	// Joystick 1 I/O ports
	localparam logic [7:0] JOY_DIR_PORT = 8'h2E;
	localparam logic [7:0] JOY_ARM_PORT = 8'h2D;

	// Last step of the CPU clock period
	localparam logic [3:0] SEQ_TURBO_LAST  = 4'd3;	// 4 cycles
	localparam logic [3:0] SEQ_NORMAL_LAST = 4'd13;	// 14 cycles

	// Returned for unmapped space and unused ports
	localparam logic [7:0] IDLE_BYTE = 8'hFF;

endpackage

// ==== source/memory_map.sv ====
`timescale 1ns/10ps

module memory_map (
	input  logic             CLK50MHZ,
	input  logic             bus_strobe_i,
	input  laser_pkg::addr_t cpu_addr_i,
	input  laser_pkg::byte_t cpu_data_i,
	input  logic             mreq_i,
	input  logic             iorq_i,
	input  logic             wr_i,
	input  laser_pkg::byte_t key_data_i,
	input  laser_pkg::byte_t joy_data_i,
	output laser_pkg::byte_t cpu_data_o,
	output logic             io_sel_o,
	output logic             joy_sel_o
);

	logic             io_blk;
	logic             vram_blk;
	logic             ram_blk;
	logic             ram_we;
	logic             vram_we;
	logic             mem_wr;
	laser_pkg::byte_t ram_q;
	laser_pkg::byte_t vram_q;

	assign io_blk   = (cpu_addr_i[15:11] == laser_pkg::IO_BASE);
	assign vram_blk = (cpu_addr_i[15:11] == laser_pkg::VRAM_BASE);

	// 7800-7FFF, 8000-AFFF and B000-B7FF
	assign ram_blk = (cpu_addr_i[15:11] == laser_pkg::RAM_LO_BASE)
		|| ((cpu_addr_i[15:12] >= laser_pkg::RAM_HI_FIRST)
		&& (cpu_addr_i[15:12] <= laser_pkg::RAM_HI_LAST))
		|| (cpu_addr_i[15:11] == laser_pkg::RAM_HI_TAIL);

	assign io_sel_o  = mreq_i && io_blk;
	assign joy_sel_o = iorq_i && ((cpu_addr_i[7:0] == laser_pkg::JOY_DIR_PORT)
		|| (cpu_addr_i[7:0] == laser_pkg::JOY_ARM_PORT));

	// Write lands at the end of the strobe cycle
	assign mem_wr  = bus_strobe_i && mreq_i && wr_i;
	assign ram_we  = mem_wr && ram_blk;
	assign vram_we = mem_wr && vram_blk;

	byte_ram #(.ADDR_W(laser_pkg::RAM_ADDR_W)) ram16k (
		.CLK50MHZ (CLK50MHZ),
		.we_i     (ram_we),
		.addr_i   (cpu_addr_i[laser_pkg::RAM_ADDR_W-1:0]),
		.data_i   (cpu_data_i),
		.q_o      (ram_q)
	);

	byte_ram #(.ADDR_W(laser_pkg::VRAM_ADDR_W)) vram (
		.CLK50MHZ (CLK50MHZ),
		.we_i     (vram_we),
		.addr_i   (cpu_addr_i[laser_pkg::VRAM_ADDR_W-1:0]),
		.data_i   (cpu_data_i),
		.q_o      (vram_q)
	);

	always_comb
	begin
		if (iorq_i)
			cpu_data_o = joy_sel_o ? joy_data_i : laser_pkg::IDLE_BYTE;
		else if (io_sel_o)
			cpu_data_o = key_data_i;	// Latched keyboard column
		else if (mreq_i && vram_blk)
			cpu_data_o = vram_q;
		else if (mreq_i && ram_blk)
			cpu_data_o = ram_q;
		else
			cpu_data_o = laser_pkg::IDLE_BYTE;
	end

endmodule

// ==== tb/tb_laser310.sv ====
`timescale 1ns/10ps

module tb_laser310;

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_KEY, OP_JOY, OP_LATCH, OP_PERIOD} op_t;

	typedef struct packed {
		op_t              op;
		laser_pkg::addr_t addr;
		laser_pkg::byte_t data;	// Write byte, latch byte or {arm, fire, right, left, down, up}
		laser_pkg::scan_t scan;
		logic             pressed;
		logic             turbo;
		laser_pkg::byte_t exp;	// Read byte or CPU clock period
	} row_t;

	logic CLK50MHZ = 1'b0;
	logic RESET_N, turbo_i, mreq_i, iorq_i, rd_i, wr_i;
	logic key_strobe_i, key_pressed_i, fire_i, up_i, down_i, left_i, right_i, arm_i;
	laser_pkg::addr_t cpu_addr_i;
	laser_pkg::byte_t cpu_data_i, cpu_data_o;
	laser_pkg::scan_t key_code_i;
	logic cpu_clk_o, cass_out_o, vdg_ag_o, vdg_css_o;
	logic [1:0] speaker_o;

	row_t        rows [$];
	logic [31:0] lcg_state = 32'hd4755c28;
	int          errors = 0;
	int          checks = 0;
	logic        row_failed;
	int          cycle_count = 0;
	int          timeout_limit = 100000;

	laser310_core uut (
		.CLK50MHZ (CLK50MHZ), .RESET_N (RESET_N), .turbo_i (turbo_i),
		.cpu_addr_i (cpu_addr_i), .cpu_data_i (cpu_data_i), .mreq_i (mreq_i),
		.iorq_i (iorq_i), .rd_i (rd_i), .wr_i (wr_i), .key_strobe_i (key_strobe_i),
		.key_pressed_i (key_pressed_i), .key_code_i (key_code_i), .fire_i (fire_i),
		.up_i (up_i), .down_i (down_i), .left_i (left_i), .right_i (right_i),
		.arm_i (arm_i), .cpu_clk_o (cpu_clk_o), .cpu_data_o (cpu_data_o),
		.speaker_o (speaker_o), .cass_out_o (cass_out_o), .vdg_ag_o (vdg_ag_o),
		.vdg_css_o (vdg_css_o)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;	// 50 MHz

	always @(posedge CLK50MHZ)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("Timeout after %0d cycles, the bus cycles did not complete", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_byte(output laser_pkg::byte_t b);
		lcg_state = lcg_step(lcg_state);
		b = lcg_state[31:24];	// Upper bits are the most random
	endtask

	task automatic add_row(input op_t op, input laser_pkg::addr_t addr,
		input laser_pkg::byte_t data, input laser_pkg::scan_t scan, input logic pressed,
		input logic turbo, input laser_pkg::byte_t exp);
		rows.push_back('{op, addr, data, scan, pressed, turbo, exp});
	endtask

	task automatic check_byte(input string name, input laser_pkg::byte_t got,
		input laser_pkg::byte_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
			row_failed = 1'b1;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
			row_failed = 1'b1;
		end
	endtask

	// Returns on the edge where the CPU clock pulse is seen
	task automatic wait_pulse(output int cycles);
		int count;
		count = 0;
		do
		begin
			@(posedge CLK50MHZ);
			count++;
		end
		while (cpu_clk_o !== 1'b1);
		cycles = count;
	endtask

	task automatic drive_bus(input laser_pkg::addr_t addr, input laser_pkg::byte_t data,
		input logic mreq, input logic iorq, input logic rd, input logic wr);
		cpu_addr_i <= addr;
		cpu_data_i <= data;
		mreq_i     <= mreq;
		iorq_i     <= iorq;
		rd_i       <= rd;
		wr_i       <= wr;
	endtask

	// Called on a pulse edge and returns on one
	task automatic run_row(input row_t r);
		int n;
		turbo_i <= r.turbo;
		case (r.op)
			OP_WRITE, OP_LATCH:
			begin
				drive_bus(r.addr, r.data, 1'b1, 1'b0, 1'b0, 1'b1);
				wait_pulse(n);
				if (r.op == OP_LATCH)
				begin
					check_bit("speaker_o[1]", speaker_o[1], r.data[0]);
					check_bit("speaker_o[0]", speaker_o[0], r.data[5]);
					check_bit("cass_out_o", cass_out_o, r.data[2]);
					check_bit("vdg_ag_o", vdg_ag_o, r.data[3]);
					check_bit("vdg_css_o", vdg_css_o, r.data[4]);
				end
			end
			OP_KEY:
			begin
				drive_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
				key_code_i    <= r.scan;
				key_pressed_i <= r.pressed;
				key_strobe_i  <= 1'b1;
				@(posedge CLK50MHZ);
				key_strobe_i  <= 1'b0;
				wait_pulse(n);
				drive_bus(r.addr, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0);
				wait_pulse(n);
				check_byte("cpu_data_o", cpu_data_o, r.exp);
			end
			OP_PERIOD:
			begin
				drive_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
				wait_pulse(n);	// Current period keeps its old length
				wait_pulse(n);
				check_byte("cpu_clk_o period", laser_pkg::byte_t'(n), r.exp);
			end
			default:
			begin
				{arm_i, fire_i, right_i, left_i, down_i, up_i} <= r.data[5:0];
				drive_bus(r.addr, 8'h00, r.op == OP_READ, r.op == OP_JOY, 1'b1, 1'b0);
				wait_pulse(n);
				check_byte("cpu_data_o", cpu_data_o, r.exp);
			end
		endcase
	endtask

	initial
	begin
		laser_pkg::byte_t d [6];
		int n;
		foreach (d[k])
			next_byte(d[k]);
		add_row(OP_WRITE, 16'h7800, d[0], 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(OP_WRITE, 16'h8000, d[1], 8'h00, 1'b0, 1'b0, 8'h00);
		add_row(OP_WRITE, 16'hB7FF, d[2], 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(OP_WRITE, 16'h77FF, d[3], 8'h00, 1'b0, 1'b0, 8'h00);	// VRAM twin of B7FF
		add_row(OP_WRITE, 16'h7000, d[4], 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(OP_READ,  16'h7800, 8'h00, 8'h00, 1'b0, 1'b0, d[0]);
		add_row(OP_READ,  16'h8000, 8'h00, 8'h00, 1'b0, 1'b1, d[1]);
		add_row(OP_READ,  16'hB7FF, 8'h00, 8'h00, 1'b0, 1'b0, d[2]);
		add_row(OP_READ,  16'h77FF, 8'h00, 8'h00, 1'b0, 1'b1, d[3]);
		add_row(OP_READ,  16'h7000, 8'h00, 8'h00, 1'b0, 1'b0, d[4]);
		add_row(OP_READ,  16'h0000, 8'h00, 8'h00, 1'b0, 1'b1, 8'hFF);
		add_row(OP_READ,  16'h4000, 8'h00, 8'h00, 1'b0, 1'b0, 8'hFF);
		add_row(OP_READ,  16'hC000, 8'h00, 8'h00, 1'b0, 1'b1, 8'hFF);
		add_row(OP_KEY,   16'h68FD, 8'h00, 8'h1C, 1'b1, 1'b1, 8'hEF);	// A at row 1 column 4
		add_row(OP_READ,  16'h68FE, 8'h00, 8'h00, 1'b0, 1'b1, 8'hFF);
		add_row(OP_KEY,   16'h68FD, 8'h00, 8'h1C, 1'b0, 1'b0, 8'hFF);
		add_row(OP_KEY,   16'h68BF, 8'h00, 8'h5A, 1'b1, 1'b1, 8'hFB);	// Return at row 6 column 2
		add_row(OP_KEY,   16'h68BF, 8'h00, 8'h5A, 1'b0, 1'b0, 8'hFF);
		add_row(OP_KEY,   16'h6800, 8'h00, 8'h76, 1'b1, 1'b1, 8'hFF);	// Esc is not mapped
		add_row(OP_LATCH, 16'h6800, 8'h01, 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(OP_LATCH, 16'h6800, 8'h3C, 8'h00, 1'b0, 1'b0, 8'h00);
		add_row(OP_LATCH, 16'h6800, d[5], 8'h00, 1'b0, 1'b1, 8'h00);
		add_row(OP_JOY,   16'h002E, 8'h15, 8'h00, 1'b0, 1'b1, 8'hEA);
		add_row(OP_JOY,   16'h002E, 8'h0A, 8'h00, 1'b0, 1'b0, 8'hF5);
		add_row(OP_JOY,   16'h002D, 8'h20, 8'h00, 1'b0, 1'b1, 8'hEF);
		add_row(OP_JOY,   16'h002D, 8'h1F, 8'h00, 1'b0, 1'b0, 8'hFF);
		add_row(OP_JOY,   16'h0010, 8'h3F, 8'h00, 1'b0, 1'b0, 8'hFF);
		add_row(OP_PERIOD, 16'h0000, 8'h00, 8'h00, 1'b0, 1'b1, 8'd4);
		add_row(OP_PERIOD, 16'h0000, 8'h00, 8'h00, 1'b0, 1'b0, 8'd14);
		timeout_limit = rows.size() * 2 * 14 + 200;

		RESET_N = 1'b0;
		turbo_i = 1'b1;
		cpu_addr_i = 16'h0000;
		cpu_data_i = 8'h00;
		{mreq_i, iorq_i, rd_i, wr_i} = 4'b0000;
		{key_strobe_i, key_pressed_i} = 2'b00;
		key_code_i = 8'h00;
		{fire_i, up_i, down_i, left_i, right_i, arm_i} = 6'b000000;
		repeat (16) @(posedge CLK50MHZ);
		RESET_N <= 1'b1;

		row_failed = 1'b0;
		check_bit("speaker_o[1]", speaker_o[1], 1'b0);
		check_bit("speaker_o[0]", speaker_o[0], 1'b0);
		check_bit("cass_out_o", cass_out_o, 1'b0);
		check_bit("vdg_ag_o", vdg_ag_o, 1'b0);
		check_bit("vdg_css_o", vdg_css_o, 1'b0);
		$display("reset latch state: %s", row_failed ? "FAIL" : "ok");

		wait_pulse(n);	// Line up with the first CPU clock pulse
		foreach (rows[i])
		begin
			row_failed = 1'b0;
			run_row(rows[i]);
			$display("row %0d %s addr %h: %s", i, rows[i].op.name(), rows[i].addr,
				row_failed ? "FAIL" : "ok");
		end

		errors = errors + uut.u_seq.seq_props.failures;	// Sequencer assertion failures
		$display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== tb/tb_laser310_properties.sv ====
`timescale 1ns/10ps

module tb_laser310_properties (
	input logic CLK50MHZ,
	input logic RESET_N,
	input logic cpu_clk_o,
	input logic bus_strobe_o
);

	int failures = 0;

	// Strobe in the cycle after the pulse, then at least two quiet cycles
	strobe_follows_clk: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |=> (bus_strobe_o && !cpu_clk_o)
		##1 (!bus_strobe_o && !cpu_clk_o) ##1 (!bus_strobe_o && !cpu_clk_o))
		else
		begin
			$error("bus strobe does not follow the CPU clock pulse by one cycle");
			failures = failures + 1;
		end

	single_cycle_pulse: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		cpu_clk_o |=> !cpu_clk_o)
		else
		begin
			$error("CPU clock high for two cycles in a row");
			failures = failures + 1;
		end

	// Both held low while reset is applied
	quiet_in_reset: assert property (@(posedge CLK50MHZ)
		!RESET_N |=> (!cpu_clk_o && !bus_strobe_o))
		else
		begin
			$error("CPU clock or bus strobe active during reset");
			failures = failures + 1;
		end

endmodule

bind cpu_clock_seq tb_laser310_properties seq_props (.*);
